// File: fetch_control.sv
module fetch_control (
  input  logic                   clk,
  input  logic                   reset,
  // pipeline stall from downstream
  input  logic                   hold,
  input  logic                   wb_ack,
  // current ID stage contents
  input  logic                   id_valid,
  input  mips_fetch_pkg::instr_t id_instr,
  // redirect request from next_pc
  input  logic                   c_if_flush,
  // Wishbone classic master, read only
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  // word handling at the ack edge
  output logic                   fetch_ack_take,
  output logic                   redirect,
  // decoded ID controls into next_pc
  output logic                   jump,
  output logic                   branch,
  output logic                   bne
);

  import mips_fetch_pkg::*;

  logic [1:0] state;
  logic [1:0] state_nxt;
  logic       ack_seen;

  // ack only counts while a cycle is open
  assign ack_seen = (state == ST_REQ) && wb_ack;

  // sequencer
  // idle waits for hold to drop, req waits for ack,
  // gap gives the one dead cycle the slave expects
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (!hold) begin
          state_nxt = ST_REQ;
        end
      end
      ST_REQ: begin
        // never aborted, hold does not matter here
        if (wb_ack) begin
          state_nxt = ST_GAP;
        end
      end
      ST_GAP: begin
        if (hold) begin
          state_nxt = ST_IDLE;
        end else begin
          state_nxt = ST_REQ;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // cyc and stb rise and fall together
  assign wb_cyc = (state == ST_REQ);
  assign wb_stb = (state == ST_REQ);
  // instruction fetch never writes
  assign wb_we  = 1'b0;

  // a taken branch or jump in ID kills the word just fetched
  assign redirect       = ack_seen && id_valid && c_if_flush;
  assign fetch_ack_take = ack_seen && !redirect;

  // opcode decode
  // a bubble in IF/ID must never steer the pc
  always_comb begin
    jump   = 1'b0;
    branch = 1'b0;
    bne    = 1'b0;
    if (id_valid) begin
      case (id_instr.i.opcode)
        OP_J: begin
          jump = 1'b1;
        end
        OP_BEQ: begin
          branch = 1'b1;
        end
        OP_BNE: begin
          // bne is a branch with inverted compare
          branch = 1'b1;
          bne    = 1'b1;
        end
        default: begin
          jump = 1'b0;
        end
      endcase
    end
  end

endmodule

// File: fetch_regs.sv
module fetch_regs (
  input  logic                   clk,
  input  logic                   reset,
  // fetched word accepted into IF/ID
  input  logic                   fetch_ack_take,
  // fetched word dropped, pc takes the branch or jump target
  input  logic                   redirect,
  input  logic [31:0]            next,
  input  mips_fetch_pkg::instr_t fetch_word,
  output logic [31:0]            pc,
  output logic [31:0]            id_pc,
  output mips_fetch_pkg::instr_t id_instr,
  output logic                   id_valid,
  output logic                   id_issue
);

  import mips_fetch_pkg::*;

  // fetch pc
  // only moves at the end of a bus cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (redirect) begin
      pc <= next;
    end else if (fetch_ack_take) begin
      pc <= pc + 32'd4;
    end
  end

  // IF/ID payload
  // pc and word are captured together on a take
  always_ff @(posedge clk) begin
    if (fetch_ack_take) begin
      id_pc    <= pc;
      id_instr <= fetch_word;
    end
  end

  // valid bit
  // a redirect turns IF/ID into a bubble
  always_ff @(posedge clk) begin
    if (reset) begin
      id_valid <= 1'b0;
    end else if (redirect) begin
      id_valid <= 1'b0;
    end else if (fetch_ack_take) begin
      id_valid <= 1'b1;
    end
  end

  // one-cycle strobe alongside the new IF/ID contents
  always_ff @(posedge clk) begin
    if (reset) begin
      id_issue <= 1'b0;
    end else begin
      id_issue <= fetch_ack_take;
    end
  end

endmodule

// File: fetch_unit.f
mips_fetch_pkg.sv
next_pc.sv
reg_file_compare.sv
fetch_regs.sv
fetch_control.sv
fetch_unit.sv
tb_imem.sv
fetch_unit_asserts.sv
tb_fetch_unit.sv

// File: fetch_unit.sv
module fetch_unit (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   hold,
  // Wishbone classic instruction bus
  input  logic [31:0]            wb_dat_i,
  input  logic                   wb_ack,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [31:0]            wb_adr,
  // issue stream to the rest of the pipeline
  output logic                   id_issue,
  output logic [31:0]            id_pc,
  output mips_fetch_pkg::instr_t id_instr,
  // register file write port
  input  logic                   rf_we,
  input  logic [4:0]             rf_waddr,
  input  logic [31:0]            rf_wdata
);

  import mips_fetch_pkg::*;

  logic        fetch_ack_take;
  logic        redirect;
  logic        jump;
  logic        branch;
  logic        bne;
  logic        zero;
  logic [31:0] next;
  logic        c_if_flush;
  logic [31:0] pc;
  logic        id_valid;

  // bus address is the fetch pc
  assign wb_adr = pc;

  fetch_control u_fetch_control (
    .clk            (clk),
    .reset          (reset),
    .hold           (hold),
    .wb_ack         (wb_ack),
    .id_valid       (id_valid),
    .id_instr       (id_instr),
    .c_if_flush     (c_if_flush),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .fetch_ack_take (fetch_ack_take),
    .redirect       (redirect),
    .jump           (jump),
    .branch         (branch),
    .bne            (bne)
  );

  // next_pc works on the ID instruction and its own pc
  next_pc u_next_pc (
    .old        (id_pc),
    .instru     (id_instr),
    .jump       (jump),
    .branch     (branch),
    .bne        (bne),
    .zero       (zero),
    .next       (next),
    .c_if_flush (c_if_flush)
  );

  reg_file_compare u_reg_file_compare (
    .clk   (clk),
    .we    (rf_we),
    .waddr (rf_waddr),
    .wdata (rf_wdata),
    .rs    (id_instr.i.rs),
    .rt    (id_instr.i.rt),
    .zero  (zero)
  );

  fetch_regs u_fetch_regs (
    .clk            (clk),
    .reset          (reset),
    .fetch_ack_take (fetch_ack_take),
    .redirect       (redirect),
    .next           (next),
    .fetch_word     (wb_dat_i),
    .pc             (pc),
    .id_pc          (id_pc),
    .id_instr       (id_instr),
    .id_valid       (id_valid),
    .id_issue       (id_issue)
  );

endmodule

// File: fetch_unit_asserts.sv
module fetch_unit_asserts (
  input logic        clk,
  input logic        reset,
  input logic        hold,
  input logic        wb_cyc,
  input logic        wb_stb,
  input logic        wb_ack,
  input logic [31:0] wb_adr,
  input logic        id_issue
);
  timeunit 1ns;
  timeprecision 1ps;

  // failures so far, picked up by the testbench at the end of the run
  int unsigned fail_count;

  initial fail_count = 0;

  // strobe only inside a cycle
  stb_in_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
    else begin
      $error("wb_stb high while wb_cyc is low");
      fail_count++;
    end

  // address held until the slave acks
  adr_stable: assert property (@(posedge clk) disable iff (reset)
      (wb_stb && !wb_ack) |=> $stable(wb_adr))
    else begin
      $error("wb_adr changed during a pending request");
      fail_count++;
    end

  // one dead cycle after every ack
  gap_after_ack: assert property (@(posedge clk) disable iff (reset)
      (wb_cyc && wb_ack) |=> !wb_cyc)
    else begin
      $error("wb_cyc still high in the cycle after ack");
      fail_count++;
    end

  // a cycle only opens when hold was low
  no_start_in_hold: assert property (@(posedge clk) disable iff (reset)
      $rose(wb_cyc) |-> !$past(hold))
    else begin
      $error("bus cycle started while hold was high");
      fail_count++;
    end

  // issue is a single-cycle strobe
  issue_strobe: assert property (@(posedge clk) disable iff (reset) id_issue |=> !id_issue)
    else begin
      $error("id_issue high on two consecutive cycles");
      fail_count++;
    end

endmodule

bind fetch_unit fetch_unit_asserts u_asserts (
  .clk      (clk),
  .reset    (reset),
  .hold     (hold),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_ack   (wb_ack),
  .wb_adr   (wb_adr),
  .id_issue (id_issue)
);

// File: mips_fetch_pkg.sv
package mips_fetch_pkg;

  // primary opcodes handled by the front end
  localparam logic [5:0] OP_J   = 6'd2;
  localparam logic [5:0] OP_BEQ = 6'd4;
  localparam logic [5:0] OP_BNE = 6'd5;

  // first fetch address out of reset
  localparam logic [31:0] RESET_PC = 32'h0000_0000;

  // fetch sequencer states
  localparam logic [1:0] ST_IDLE = 2'd0;
  // cyc and stb asserted, waiting on ack
  localparam logic [1:0] ST_REQ  = 2'd1;
  // forced dead cycle after every ack
  localparam logic [1:0] ST_GAP  = 2'd2;

  // i-format view
  // beq and bne use rs, rt and the 16-bit word offset
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  // j-format view
  // target is a word index within the current 256 MB region
  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } j_fmt_t;

  // one instruction word, decoded either way
  // opcode sits in the same bits for both views
  typedef union packed {
    i_fmt_t i;
    j_fmt_t j;
  } instr_t;

endpackage

// File: next_pc.sv
module next_pc (
  // IF/ID pc of the instruction in decode
  input  logic [31:0]           old,
  // IF/ID instruction word
  input  mips_fetch_pkg::instr_t instru,
  // decoded controls, already qualified by id_valid
  input  logic                  jump,
  input  logic                  branch,
  input  logic                  bne,
  // rs == rt from the register file comparator
  input  logic                  zero,
  output logic [31:0]           next,
  output logic                  c_if_flush
);

  import mips_fetch_pkg::*;

  logic [31:0] pc_plus4;
  logic [31:0] jump_addr;
  logic [31:0] sign_ext;
  logic [31:0] branch_addr;
  logic        cond;
  logic        taken;

  // sequential successor
  assign pc_plus4 = old + 32'd4;

  // region bits come from pc+4, target is a word index
  assign jump_addr = {pc_plus4[31:28], instru.j.target, 2'b00};

  // offset counts words, so shift after sign extension
  assign sign_ext    = {{16{instru.i.imm[15]}}, instru.i.imm};
  assign branch_addr = pc_plus4 + {sign_ext[29:0], 2'b00};

  // bne wants the opposite sense of the comparator
  assign cond  = bne ? ~zero : zero;
  assign taken = branch & cond;

  // jump has priority over a branch
  always_comb begin
    if (jump) begin
      next       = jump_addr;
      c_if_flush = 1'b1;
    end else if (taken) begin
      next       = branch_addr;
      c_if_flush = 1'b1;
    end else begin
      next       = pc_plus4;
      c_if_flush = 1'b0;
    end
  end

endmodule

// File: reg_file_compare.sv
module reg_file_compare (
  input  logic        clk,
  // external write port, stands in for writeback
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata,
  // source fields of the ID instruction
  input  logic [4:0]  rs,
  input  logic [4:0]  rt,
  // high when both operands are equal
  output logic        zero
);

  import mips_fetch_pkg::*;

  // entry 0 is never written and never read
  logic [31:0] regs [1:31];

  logic [31:0] rs_data;
  logic [31:0] rt_data;

  // writes to r0 are dropped
  always_ff @(posedge clk) begin
    if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational read ports
  // r0 always reads as zero
  always_comb begin
    if (rs == 5'd0) begin
      rs_data = 32'd0;
    end else begin
      rs_data = regs[rs];
    end
  end

  always_comb begin
    if (rt == 5'd0) begin
      rt_data = 32'd0;
    end else begin
      rt_data = regs[rt];
    end
  end

  // early branch compare in ID, no ALU involved
  // the write in the same cycle is not forwarded
  assign zero = (rs_data == rt_data);

endmodule

// File: run_sim.sh
#!/bin/sh
# build the fetch unit testbench with Verilator, run it, then judge the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_fetch_unit \
  -f fetch_unit.f -o sim_fetch_unit > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_fetch_unit +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "Regression passed" sim.log && echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }

// File: tb_fetch_unit.sv
module tb_fetch_unit;
  timeunit 1ns;
  timeprecision 1ps;

  import mips_fetch_pkg::*;

  localparam int MEM_WORDS  = 256;
  localparam int CLK_PERIOD = 10;
  localparam int NUM_TESTS  = 5;
  localparam int ISSUES     = 24;
  // six cycles per issue, doubled for margin
  localparam int WATCHDOG_NS = NUM_TESTS * ISSUES * 6 * CLK_PERIOD * 2;

  logic        clk;
  logic        reset;
  logic        hold;
  logic [31:0] wb_dat_i;
  logic        wb_ack;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic        id_issue;
  logic [31:0] id_pc;
  instr_t      id_instr;
  logic        rf_we;
  logic [4:0]  rf_waddr;
  logic [31:0] rf_wdata;

  // program image and register copy for the reference model
  logic [31:0] prog [0:MEM_WORDS-1];
  logic [31:0] tb_regs [0:31];

  string       test_name;
  logic        checking;
  logic        hold_random;
  logic [31:0] exp_pc;
  int          issue_count;
  int          error_count;
  int          total_issues;

  fetch_unit UUT (
    .clk      (clk),
    .reset    (reset),
    .hold     (hold),
    .wb_dat_i (wb_dat_i),
    .wb_ack   (wb_ack),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .id_issue (id_issue),
    .id_pc    (id_pc),
    .id_instr (id_instr),
    .rf_we    (rf_we),
    .rf_waddr (rf_waddr),
    .rf_wdata (rf_wdata)
  );

  tb_imem u_imem (
    .clk   (clk),
    .reset (reset),
    .cyc   (wb_cyc),
    .stb   (wb_stb),
    .we    (wb_we),
    .adr   (wb_adr),
    .dat_o (wb_dat_i),
    .ack   (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // addi-style filler, never touches the pc
  function automatic logic [31:0] fill_word(input int idx);
    return {6'd8, 5'(idx), 5'(idx >> 5), 16'(idx * 257 + 3)};
  endfunction

  function automatic logic [31:0] enc_branch(input logic [5:0] op, input int rs,
                                             input int rt, input int offs);
    return {op, 5'(rs), 5'(rt), 16'(offs)};
  endfunction

  // target is a word index
  function automatic logic [31:0] enc_jump(input int idx);
    return {OP_J, 26'(idx)};
  endfunction

  function automatic logic [31:0] prog_word(input logic [31:0] pc);
    if (pc[31:10] != 22'd0) begin
      return 32'd0;
    end
    return prog[pc[9:2]];
  endfunction

  // next fetch address seen after the instruction at pc leaves ID
  function automatic logic [31:0] ref_next_pc(input logic [31:0] pc, input instr_t ins,
                                              input logic [31:0] regs [0:31]);
    logic [31:0] seq;
    logic [31:0] offs;
    logic        same;
    seq  = pc + 32'd4;
    offs = {{14{ins.i.imm[15]}}, ins.i.imm, 2'b00};
    same = (regs[ins.i.rs] == regs[ins.i.rt]);
    case (ins.i.opcode)
      OP_J:    return {seq[31:28], ins.j.target, 2'b00};
      OP_BEQ:  return same ? seq + offs : seq;
      OP_BNE:  return same ? seq : seq + offs;
      default: return seq;
    endcase
  endfunction

  task automatic clear_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      prog[i] = fill_word(i);
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      u_imem.mem[i] = prog[i];
    end
  endtask

  // two reset cycles, r1 and r2 written one per cycle
  task automatic pulse_reset(input logic [31:0] r1_val, input logic [31:0] r2_val);
    @(posedge clk);
    #1;
    reset    = 1'b1;
    rf_we    = 1'b1;
    rf_waddr = 5'd1;
    rf_wdata = r1_val;
    tb_regs[1] = r1_val;
    @(posedge clk);
    #1;
    rf_waddr = 5'd2;
    rf_wdata = r2_val;
    tb_regs[2] = r2_val;
    exp_pc      = RESET_PC;
    issue_count = 0;
    checking    = 1'b1;
    @(posedge clk);
    #1;
    reset = 1'b0;
    rf_we = 1'b0;
  endtask

  task automatic run_test(input string name, input logic [31:0] r1_val,
                          input logic [31:0] r2_val, input logic use_hold);
    int errs_before;
    errs_before = error_count;
    test_name   = name;
    load_program();
    pulse_reset(r1_val, r2_val);
    hold_random = use_hold;
    while (issue_count < ISSUES) begin
      @(posedge clk);
    end
    checking     = 1'b0;
    hold_random  = 1'b0;
    total_issues = total_issues + issue_count;
    $display("test %s: %0d issues, %0d errors", name, issue_count, error_count - errs_before);
  endtask

  // roughly one cycle in four under hold when enabled
  initial begin
    forever begin
      @(posedge clk);
      #1;
      if (hold_random) begin
        hold = ($urandom_range(3, 0) == 0);
      end else begin
        hold = 1'b0;
      end
    end
  end

  // IF/ID is stable by the falling edge
  always @(negedge clk) begin
    logic [31:0] exp_word;
    logic [31:0] act_word;
    if (!reset && checking) begin
      // fetch bus is read only
      assert (wb_we == 1'b0) else begin
        $display("ERROR %s wb_we: expected %b, actual %b", test_name, 1'b0, wb_we);
        error_count++;
      end
    end
    if (!reset && checking && id_issue && issue_count < ISSUES) begin
      exp_word = prog_word(exp_pc);
      act_word = id_instr;
      assert (id_pc == exp_pc) else begin
        $display("ERROR %s issue %0d pc: expected %h, actual %h",
                 test_name, issue_count, exp_pc, id_pc);
        error_count++;
      end
      assert (act_word == exp_word) else begin
        $display("ERROR %s issue %0d instr: expected %h, actual %h",
                 test_name, issue_count, exp_word, act_word);
        error_count++;
      end
      exp_pc = ref_next_pc(exp_pc, exp_word, tb_regs);
      issue_count++;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("run timed out after %0d ns before all tests finished", WATCHDOG_NS);
    $display("Regression failed");
    $finish;
  end

  initial begin
    void'($urandom(59));
    reset        = 1'b1;
    hold         = 1'b0;
    rf_we        = 1'b0;
    rf_waddr     = 5'd0;
    rf_wdata     = 32'd0;
    checking     = 1'b0;
    hold_random  = 1'b0;
    exp_pc       = RESET_PC;
    issue_count  = 0;
    error_count  = 0;
    total_issues = 0;
    foreach (tb_regs[i]) begin
      tb_regs[i] = 32'd0;
    end

    // straight line from reset
    clear_program();
    run_test("straight_line", 32'd0, 32'd0, 1'b0);

    // loop 2,3 -> 10,11,12 -> 2
    clear_program();
    prog[3]  = enc_jump(10);
    prog[12] = enc_jump(2);
    run_test("jump", 32'd0, 32'd0, 1'b0);

    // equal r1/r2, taken forward, fall through, backward loop
    clear_program();
    prog[1] = enc_branch(OP_BEQ, 1, 2, 3);
    prog[5] = enc_branch(OP_BEQ, 1, 0, 10);
    prog[7] = enc_branch(OP_BEQ, 2, 1, -7);
    run_test("beq", 32'h1234_5678, 32'h1234_5678, 1'b0);

    // r1 zero so it matches r0
    clear_program();
    prog[2]  = enc_branch(OP_BNE, 2, 1, 4);
    prog[7]  = enc_branch(OP_BNE, 1, 0, 5);
    prog[8]  = enc_branch(OP_BEQ, 1, 0, 2);
    prog[11] = enc_branch(OP_BNE, 2, 2, 1);
    prog[12] = enc_branch(OP_BNE, 0, 2, -12);
    run_test("bne", 32'd0, 32'h0000_00a5, 1'b0);

    // same program, only the spacing should move
    run_test("random_hold", 32'd0, 32'h0000_00a5, 1'b1);

    $display("tests %0d, issues %0d, errors %0d, assertion failures %0d",
             NUM_TESTS, total_issues, error_count, UUT.u_asserts.fail_count);
    if (error_count == 0 && UUT.u_asserts.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: tb_imem.sv
module tb_imem (
  input  logic        clk,
  input  logic        reset,
  // Wishbone classic slave side
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [31:0] adr,
  output logic [31:0] dat_o,
  output logic        ack
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WORDS = 256;

  // program image, loaded by the testbench before each reset
  logic [31:0] mem [0:WORDS-1];

  logic       busy;
  logic [1:0] wait_cnt;

  // anything past the array reads as zero
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (addr[31:10] != 22'd0) begin
      return 32'd0;
    end
    return mem[addr[9:2]];
  endfunction

  // responds 1 ns after the edge, like the rest of the stimulus
  // 0 to 2 wait states picked at the start of each cycle
  initial begin
    ack      = 1'b0;
    dat_o    = 32'd0;
    busy     = 1'b0;
    wait_cnt = 2'd0;
    forever begin
      @(posedge clk);
      #1;
      if (reset) begin
        ack  = 1'b0;
        busy = 1'b0;
      end else if (ack) begin
        // master took the word at this edge
        ack  = 1'b0;
        busy = 1'b0;
      end else if (cyc && stb && !we) begin
        if (!busy) begin
          busy     = 1'b1;
          wait_cnt = 2'($urandom_range(2, 0));
        end else begin
          wait_cnt = wait_cnt - 2'd1;
        end
        if (wait_cnt == 2'd0) begin
          ack   = 1'b1;
          dat_o = read_word(adr);
        end
      end
    end
  end

endmodule
